// File: hdl/vid_pkg.sv
package vid_pkg;

    typedef logic [11:0] hcount_t;     // clocks within a line
    typedef logic [10:0] vcount_t;     // lines
    typedef logic [15:0] frame_cnt_t;
    typedef logic [2:0]  reg_addr_t;
    typedef logic [15:0] reg_data_t;

    typedef struct packed {
        hcount_t h_fp;
        hcount_t h_sync;
        hcount_t h_act;
        vcount_t v_act;
        vcount_t v_fp;
        vcount_t v_sync;
        vcount_t v_total;
    } timing_cfg_t;

    typedef struct packed {
        vcount_t    lines_last;
        hcount_t    href_max;
        frame_cnt_t frames;
    } frame_stat_t;

    typedef enum logic [2:0] {
        passive_active,
        passive_fp,
        passive_sync,
        passive_wait,
        active_wait,
        active_act,
        active_fp,
        active_sync
    } sync_state_e;

    localparam reg_addr_t ADDR_H_FP    = 3'd0;
    localparam reg_addr_t ADDR_H_SYNC  = 3'd1;
    localparam reg_addr_t ADDR_H_ACT   = 3'd2;
    localparam reg_addr_t ADDR_V_ACT   = 3'd3;
    localparam reg_addr_t ADDR_V_FP    = 3'd4;
    localparam reg_addr_t ADDR_V_SYNC  = 3'd5;
    localparam reg_addr_t ADDR_V_TOTAL = 3'd6;
    localparam reg_addr_t ADDR_STAT    = 3'd7;

    // 720p-like defaults
    localparam hcount_t RST_H_FP    = 12'd110;
    localparam hcount_t RST_H_SYNC  = 12'd40;
    localparam hcount_t RST_H_ACT   = 12'd1280;
    localparam vcount_t RST_V_ACT   = 11'd720;
    localparam vcount_t RST_V_FP    = 11'd5;
    localparam vcount_t RST_V_SYNC  = 11'd5;
    localparam vcount_t RST_V_TOTAL = 11'd750;

endpackage : vid_pkg

// File: hdl/timing_cfg_regs.sv
`timescale 1ns/1ps

module timing_cfg_regs
    import vid_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,
    input  logic        cfg_req,
    input  logic        cfg_we,
    input  reg_addr_t   cfg_addr,
    input  reg_data_t   cfg_wdata,
    output logic        cfg_ack,
    output reg_data_t   cfg_rdata,
    input  frame_stat_t stat,
    output timing_cfg_t cfg,
    output logic        clear_stat
);

    typedef enum logic {
        ack_idle,
        ack_done
    } ack_state_e;

    ack_state_e ack_state;
    logic [1:0] stat_sel;    // 0 lines_last, 1 frames, 2 href_max
    reg_data_t  rd_mux;
    logic       access;

    assign access  = (ack_state == ack_idle) && cfg_req;
    assign cfg_ack = (ack_state == ack_done);

    always_comb begin
        case (cfg_addr)
            ADDR_H_FP    : rd_mux = reg_data_t'(cfg.h_fp);
            ADDR_H_SYNC  : rd_mux = reg_data_t'(cfg.h_sync);
            ADDR_H_ACT   : rd_mux = reg_data_t'(cfg.h_act);
            ADDR_V_ACT   : rd_mux = reg_data_t'(cfg.v_act);
            ADDR_V_FP    : rd_mux = reg_data_t'(cfg.v_fp);
            ADDR_V_SYNC  : rd_mux = reg_data_t'(cfg.v_sync);
            ADDR_V_TOTAL : rd_mux = reg_data_t'(cfg.v_total);
            default : begin
                case (stat_sel)
                    2'd1    : rd_mux = reg_data_t'(stat.frames);
                    2'd2    : rd_mux = reg_data_t'(stat.href_max);
                    default : rd_mux = reg_data_t'(stat.lines_last);
                endcase
            end
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (~rstn) begin
            ack_state  <= ack_idle;
            clear_stat <= 1'b0;
            stat_sel   <= 2'd0;
            cfg        <= '{h_fp: RST_H_FP, h_sync: RST_H_SYNC, h_act: RST_H_ACT,
                            v_act: RST_V_ACT, v_fp: RST_V_FP, v_sync: RST_V_SYNC,
                            v_total: RST_V_TOTAL};
        end else begin
            clear_stat <= 1'b0;
            case (ack_state)
                ack_idle : begin
                    if (cfg_req) begin
                        ack_state <= ack_done;
                        if (cfg_we) begin
                            case (cfg_addr)
                                ADDR_H_FP    : cfg.h_fp    <= hcount_t'(cfg_wdata);
                                ADDR_H_SYNC  : cfg.h_sync  <= hcount_t'(cfg_wdata);
                                ADDR_H_ACT   : cfg.h_act   <= hcount_t'(cfg_wdata);
                                ADDR_V_ACT   : cfg.v_act   <= vcount_t'(cfg_wdata);
                                ADDR_V_FP    : cfg.v_fp    <= vcount_t'(cfg_wdata);
                                ADDR_V_SYNC  : cfg.v_sync  <= vcount_t'(cfg_wdata);
                                ADDR_V_TOTAL : cfg.v_total <= vcount_t'(cfg_wdata);
                                default : begin
                                    // stat write clears and picks the field read back
                                    clear_stat <= 1'b1;
                                    stat_sel   <= cfg_wdata[1:0];
                                end
                            endcase
                        end
                    end
                end
                ack_done : begin
                    if (!cfg_req) ack_state <= ack_idle;    // end of four-phase cycle
                end
                default : ack_state <= ack_idle;
            endcase
        end
    end

    // read data held while ack is high
    always_ff @(posedge clk) begin
        if (access && !cfg_we) cfg_rdata <= rd_mux;
    end

endmodule : timing_cfg_regs

// File: hdl/cam_frame_meter.sv
`timescale 1ns/1ps

module cam_frame_meter
    import vid_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,
    input  logic        cam_href,
    input  logic        cam_vsync,
    input  logic        clear_stat,
    output frame_stat_t stat
);

    logic       href_d;
    logic       vsync_d;
    logic       href_rise;
    logic       href_fall;
    logic       vsync_rise;
    vcount_t    line_cnt;      // href edges in the running frame
    vcount_t    lines_last;
    hcount_t    run_len;
    hcount_t    href_max;
    frame_cnt_t frames;

    assign href_rise  = cam_href & ~href_d;
    assign href_fall  = ~cam_href & href_d;
    assign vsync_rise = cam_vsync & ~vsync_d;

    assign stat = '{lines_last: lines_last, href_max: href_max, frames: frames};

    always_ff @(posedge clk or negedge rstn) begin
        if (~rstn) begin
            href_d     <= 1'b0;
            vsync_d    <= 1'b0;
            line_cnt   <= '0;
            lines_last <= '0;
            run_len    <= '0;
            href_max   <= '0;
            frames     <= '0;
        end else begin
            href_d  <= cam_href;
            vsync_d <= cam_vsync;

            if (cam_href) run_len <= href_rise ? hcount_t'(1) : run_len + 1'b1;

            if (clear_stat) begin
                line_cnt   <= '0;
                lines_last <= '0;
                href_max   <= '0;
                frames     <= '0;
            end else begin
                if (href_fall && run_len > href_max) href_max <= run_len;

                if (vsync_rise) begin
                    lines_last <= line_cnt;
                    frames     <= frames + 1'b1;
                    line_cnt   <= href_rise ? vcount_t'(1) : vcount_t'(0);
                end else if (href_rise) begin
                    line_cnt <= line_cnt + 1'b1;
                end
            end
        end
    end

endmodule : cam_frame_meter

// File: hdl/sync_gen.sv
`timescale 1ns/1ps

module sync_gen
    import vid_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,
    input  logic        cam_href,
    input  logic        cam_vsync,
    input  timing_cfg_t cfg,
    output logic        hsync,
    output logic        vsync,
    output logic        de
);

    sync_state_e state;
    logic        cam_href_d;
    logic        vsynced;           // camera vsync seen, waiting for next line end
    hcount_t     h_cnt;
    hcount_t     h_gap;             // blanking measured between camera lines
    vcount_t     v_cnt;
    vcount_t     v_next;
    logic [11:0] vs_start;
    logic [11:0] vs_end;
    logic        vs_next;

    // true on the final clock of a phase that lasts len clocks
    function automatic logic last_clk(input hcount_t cnt, input hcount_t len);
        logic [12:0] nxt;
        nxt = cnt + 13'd1;
        return nxt >= {1'b0, len};
    endfunction

    assign v_next   = v_cnt + 1'b1;
    assign vs_start = cfg.v_act + cfg.v_fp;
    assign vs_end   = vs_start + cfg.v_sync;
    assign vs_next  = ({1'b0, v_next} >= vs_start) && ({1'b0, v_next} < vs_end);

    // passive lines follow the camera, active lines are self timed
    assign de = (state inside {passive_active, passive_fp, passive_sync, passive_wait}) ?
                cam_href_d : (state == active_act);

    always_ff @(posedge clk or negedge rstn) begin
        if (~rstn) begin
            cam_href_d <= 1'b0;
        end else begin
            cam_href_d <= cam_href;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (~rstn) begin
            state   <= passive_active;
            h_cnt   <= '0;
            h_gap   <= '0;
            v_cnt   <= '0;
            hsync   <= 1'b0;
            vsync   <= 1'b0;
            vsynced <= 1'b0;
        end else begin
            if (cam_vsync) vsynced <= 1'b1;

            case (state)
                passive_active : begin
                    if (!cam_href && cam_href_d) begin
                        h_cnt <= '0;
                        state <= passive_fp;
                        if (vsynced) begin
                            vsynced <= 1'b0;
                            v_cnt   <= '0;
                        end else begin
                            v_cnt <= v_next;
                        end
                    end
                end
                passive_fp : begin
                    if (!last_clk(h_cnt, cfg.h_fp)) begin
                        h_cnt <= h_cnt + 1'b1;
                    end else begin
                        h_cnt <= '0;
                        hsync <= 1'b1;
                        state <= passive_sync;
                    end
                end
                passive_sync : begin
                    if (!last_clk(h_cnt, cfg.h_sync)) begin
                        h_cnt <= h_cnt + 1'b1;
                    end else begin
                        h_cnt <= '0;
                        hsync <= 1'b0;
                        if (v_cnt == cfg.v_act - 1'b1) begin
                            // hand over to self timing, keep last measured gap
                            v_cnt <= v_next;
                            vsync <= vs_next;
                            state <= active_wait;
                        end else begin
                            h_gap <= '0;
                            state <= passive_wait;
                        end
                    end
                end
                passive_wait : begin
                    if (cam_href && !cam_href_d) begin
                        state <= passive_active;
                    end else begin
                        h_gap <= h_gap + 1'b1;
                    end
                end

                active_wait : begin
                    if (!last_clk(h_cnt, h_gap)) begin
                        h_cnt <= h_cnt + 1'b1;
                    end else begin
                        h_cnt <= '0;
                        state <= active_act;
                    end
                end
                active_act : begin
                    if (!last_clk(h_cnt, cfg.h_act)) begin
                        h_cnt <= h_cnt + 1'b1;
                    end else begin
                        h_cnt <= '0;
                        state <= active_fp;
                    end
                end
                active_fp : begin
                    if (!last_clk(h_cnt, cfg.h_fp)) begin
                        h_cnt <= h_cnt + 1'b1;
                    end else begin
                        h_cnt <= '0;
                        hsync <= 1'b1;
                        state <= active_sync;
                    end
                end
                active_sync : begin
                    if (!last_clk(h_cnt, cfg.h_sync)) begin
                        h_cnt <= h_cnt + 1'b1;
                    end else begin
                        h_cnt <= '0;
                        hsync <= 1'b0;
                        if (v_cnt != cfg.v_total - 1'b1) begin
                            v_cnt <= v_next;
                            vsync <= vs_next;    // vsync spans the whole next line
                            state <= active_wait;
                        end else begin
                            vsync <= 1'b0;
                            state <= passive_active;
                        end
                    end
                end
                default : state <= passive_active;
            endcase
        end
    end

endmodule : sync_gen

// File: hdl/vid_timing_top.sv
`timescale 1ns/1ps

module vid_timing_top
    import vid_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  logic      cam_href,
    input  logic      cam_vsync,
    input  logic      cfg_req,
    input  logic      cfg_we,
    input  reg_addr_t cfg_addr,
    input  reg_data_t cfg_wdata,
    output logic      cfg_ack,
    output reg_data_t cfg_rdata,
    output logic      hsync,
    output logic      vsync,
    output logic      de
);

    timing_cfg_t cfg;
    frame_stat_t stat;
    logic        clear_stat;

    timing_cfg_regs i_timing_cfg_regs (
        .clk        (clk),
        .rstn       (rstn),
        .cfg_req    (cfg_req),
        .cfg_we     (cfg_we),
        .cfg_addr   (cfg_addr),
        .cfg_wdata  (cfg_wdata),
        .cfg_ack    (cfg_ack),
        .cfg_rdata  (cfg_rdata),
        .stat       (stat),
        .cfg        (cfg),
        .clear_stat (clear_stat)
    );

    cam_frame_meter i_cam_frame_meter (
        .clk        (clk),
        .rstn       (rstn),
        .cam_href   (cam_href),
        .cam_vsync  (cam_vsync),
        .clear_stat (clear_stat),
        .stat       (stat)
    );

    sync_gen i_sync_gen (
        .clk       (clk),
        .rstn      (rstn),
        .cam_href  (cam_href),
        .cam_vsync (cam_vsync),
        .cfg       (cfg),
        .hsync     (hsync),
        .vsync     (vsync),
        .de        (de)
    );

endmodule : vid_timing_top

// File: tb/tb_vid_timing.sv
`timescale 1ns/1ps

module tb_vid_timing
    import vid_pkg::*;
;

    localparam int HREF_HIGH   = 40;
    localparam int HREF_LOW    = 25;
    localparam int NUM_FRAMES  = 4;
    localparam int ACK_TIMEOUT = 20;

    typedef struct packed {
        int hs_delay;    // href fall to hsync rise
        int hs_width;
        int de_width;
        int gap;
        int act_lines;
        int vs_start;    // hsync pulses before vsync rises
        int vs_lines;
    } line_timing_t;

    logic        clk;
    logic        rstn;
    logic        cam_href;
    logic        cam_vsync;
    logic        cfg_req;
    logic        cfg_we;
    reg_addr_t   cfg_addr;
    reg_data_t   cfg_wdata;
    logic        cfg_ack;
    reg_data_t   cfg_rdata;
    logic        hsync;
    logic        vsync;
    logic        de;

    timing_cfg_t  prog;
    timing_cfg_t  rst_cfg;
    line_timing_t want;
    int unsigned  lcg_state = 32'h1dc4b2db;
    int           errors = 0;
    int           checks = 0;

    // monitor state, all counts in clocks sampled at posedge
    logic mon_on = 1'b0;
    logic in_active = 1'b0;
    logic href_prev = 1'b0;
    logic hs_prev = 1'b0;
    logic de_prev = 1'b0;
    logic vs_prev = 1'b0;
    logic cvs_prev = 1'b0;
    int   n = 0;
    int   href_fall_at = 0;
    int   hs_rise_at = 0;
    int   hs_fall_at = 0;
    int   de_rise_at = 0;
    int   hs_falls = 0;
    int   de_cnt = 0;
    int   vs_cnt = 0;
    int   gap_meas = 0;
    int   frames_done = 0;

    vid_timing_top i_vid_timing_top (
        .clk       (clk),
        .rstn      (rstn),
        .cam_href  (cam_href),
        .cam_vsync (cam_vsync),
        .cfg_req   (cfg_req),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_ack   (cfg_ack),
        .cfg_rdata (cfg_rdata),
        .hsync     (hsync),
        .vsync     (vsync),
        .de        (de)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // expected line and frame geometry
    function automatic line_timing_t ref_timing(input timing_cfg_t c, input int href_low);
        line_timing_t r;
        r.hs_delay  = int'(c.h_fp) + 1;
        r.hs_width  = int'(c.h_sync);
        r.de_width  = int'(c.h_act);
        r.gap       = href_low - r.hs_delay - r.hs_width;    // left after fp and sync
        r.act_lines = int'(c.v_total) - int'(c.v_act);
        r.vs_start  = int'(c.v_act) + int'(c.v_fp);
        r.vs_lines  = int'(c.v_sync);
        return r;
    endfunction

    // register map, address to field
    function automatic int cfg_field(input timing_cfg_t c, input int a);
        case (a)
            0       : return int'(c.h_fp);
            1       : return int'(c.h_sync);
            2       : return int'(c.h_act);
            3       : return int'(c.v_act);
            4       : return int'(c.v_fp);
            5       : return int'(c.v_sync);
            default : return int'(c.v_total);
        endcase
    endfunction

    task automatic check_value(input string what, input int got, input int exp_v);
        checks++;
        if (got !== exp_v) begin
            errors++;
            $display("[FAIL] t=%0t %s: got %0d, expected %0d", $time, what, got, exp_v);
        end
    endtask

    task automatic report_counts();
        $display("checks %0d, errors %0d", checks, errors);
    endtask

    task automatic wait_ack(input logic level);
        int cnt;
        cnt = 0;
        while (cfg_ack !== level && cnt < ACK_TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if (cfg_ack !== level) begin
            errors++;
            $display("host timeout: cfg_ack did not go to %0b within %0d clocks", level, cnt);
            report_counts();
            $display("=== FAIL ===");
            $finish;
        end
    endtask

    task automatic host_write(input int a, input int d);
        cfg_addr  = reg_addr_t'(a);
        cfg_wdata = reg_data_t'(d);
        cfg_we    = 1'b1;
        cfg_req   = 1'b1;
        wait_ack(1'b1);
        cfg_req = 1'b0;
        wait_ack(1'b0);
    endtask

    task automatic host_read(input int a, output int d);
        cfg_addr = reg_addr_t'(a);
        cfg_we   = 1'b0;
        cfg_req  = 1'b1;
        wait_ack(1'b1);
        d       = int'(cfg_rdata);    // held while ack is high
        cfg_req = 1'b0;
        wait_ack(1'b0);
    endtask

    task automatic vsync_pulse();
        cam_vsync = 1'b1;
        repeat (3) @(negedge clk);
        cam_vsync = 1'b0;
        repeat (10) @(negedge clk);
    endtask

    task automatic send_frame(input int lines);
        vsync_pulse();
        repeat (lines) begin
            cam_href = 1'b1;
            repeat (HREF_HIGH) @(negedge clk);
            cam_href = 1'b0;
            repeat (HREF_LOW) @(negedge clk);
        end
    endtask

    always @(posedge clk) begin
        if (mon_on) begin
            if (cam_vsync && !cvs_prev) begin
                if (in_active) begin
                    errors++;
                    $display("camera frame started before the active lines were done");
                end
                hs_falls  = 0;
                in_active = 1'b0;
            end
            if (!cam_href && href_prev) href_fall_at = n;
            if (hsync && !hs_prev) begin
                hs_rise_at = n;
                if (!in_active) check_value("hsync delay", n - href_fall_at, want.hs_delay);
                if (vsync) vs_cnt++;
            end
            if (!hsync && hs_prev) begin
                check_value("hsync width", n - hs_rise_at, want.hs_width);
                hs_fall_at = n;
                hs_falls++;
                if (!in_active && hs_falls == int'(prog.v_act)) begin
                    in_active = 1'b1;    // self timed lines from here
                    de_cnt    = 0;
                    vs_cnt    = 0;
                end else if (in_active && hs_falls == int'(prog.v_total)) begin
                    check_value("active lines per frame", de_cnt, want.act_lines);
                    check_value("vsync lines per frame", vs_cnt, want.vs_lines);
                    in_active = 1'b0;
                    frames_done++;
                end
            end
            if (vsync && !vs_prev) check_value("lines before vsync", hs_falls, want.vs_start);
            if (in_active) begin
                if (de && !de_prev) begin
                    de_cnt++;
                    de_rise_at = n;
                    gap_meas   = n - hs_fall_at;
                    if (gap_meas >= want.gap - 1 && gap_meas <= want.gap + 1) gap_meas = want.gap;
                    check_value("blanking gap", gap_meas, want.gap);
                end
                if (!de && de_prev) check_value("de width", n - de_rise_at, want.de_width);
            end else begin
                check_value("passive de", int'(de), int'(href_prev));
            end
        end
        n++;
        href_prev = cam_href;
        hs_prev   = hsync;
        de_prev   = de;
        vs_prev   = vsync;
        cvs_prev  = cam_vsync;
    end

    initial begin
        int a;
        int d;
        int lines;
        rstn      = 1'b0;
        cam_href  = 1'b0;
        cam_vsync = 1'b0;
        cfg_req   = 1'b0;
        cfg_we    = 1'b0;
        cfg_addr  = '0;
        cfg_wdata = '0;
        rst_cfg = '{h_fp: RST_H_FP, h_sync: RST_H_SYNC, h_act: RST_H_ACT, v_act: RST_V_ACT,
                    v_fp: RST_V_FP, v_sync: RST_V_SYNC, v_total: RST_V_TOTAL};
        prog    = '{h_fp: 12'd6, h_sync: 12'd4, h_act: 12'd40, v_act: 11'd5,
                    v_fp: 11'd2, v_sync: 11'd3, v_total: 11'd14};
        repeat (8) @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);
        check_value("hsync after reset", int'(hsync), 0);
        check_value("vsync after reset", int'(vsync), 0);
        check_value("de after reset", int'(de), 0);
        check_value("cfg_ack after reset", int'(cfg_ack), 0);
        for (a = 0; a < 7; a++) begin
            host_read(a, d);
            check_value("reset register value", d, cfg_field(rst_cfg, a));
        end
        for (a = 0; a < 7; a++) host_write(a, cfg_field(prog, a));
        for (a = 0; a < 7; a++) begin
            host_read(a, d);
            check_value("register read back", d, cfg_field(prog, a));
        end

        want   = ref_timing(prog, HREF_LOW);
        mon_on = 1'b1;
        lines  = 0;
        for (a = 0; a < NUM_FRAMES; a++) begin
            lines = 16 + int'((lcg_next() >> 16) % 8);    // enough lines for the active phase
            send_frame(lines);
        end
        vsync_pulse();    // latches the last frame's line count
        host_read(ADDR_STAT, d);
        check_value("lines of last camera frame", d, lines);

        host_write(ADDR_STAT, 1);    // clear, then read back the frame count
        send_frame(16 + int'((lcg_next() >> 16) % 8));
        host_read(ADDR_STAT, d);
        check_value("frames after clear", d, 1);

        host_write(ADDR_STAT, 2);    // clear again, longest href run this time
        send_frame(16 + int'((lcg_next() >> 16) % 8));
        host_read(ADDR_STAT, d);
        check_value("longest href after clear", d, HREF_HIGH);
        repeat (20) @(negedge clk);
        check_value("frames with a full active phase", frames_done, NUM_FRAMES + 2);

        report_counts();
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule : tb_vid_timing

// File: flist.f
hdl/vid_pkg.sv
hdl/timing_cfg_regs.sv
hdl/cam_frame_meter.sv
hdl/sync_gen.sv
hdl/vid_timing_top.sv
tb/tb_vid_timing.sv
